// ==== design/cart_bus_pkg.sv ====
////////////////////////////////////////
// host bridge bus and settings types
// bridge address map of the settings bank
// settings defaults
////////////////////////////////////////

`default_nettype none

package cart_bus_pkg;

	typedef struct packed {
		logic [31:0] addr;
		logic        rd;
		logic        wr;
		logic [31:0] wr_data;
	} bridge_bus_t;

	typedef struct packed {
		logic [1:0] cpu_turbo;
		logic       multitap;
		logic       ar_correction;
		logic       composite;
		logic       obj_limit_high;
		logic       fm_enable;
		logic       psg_enable;
		logic       hifi_pcm;
		logic       ladder;
		logic [1:0] audio_filter;
		logic       fm_chip;
	} core_settings_t;

	////////////////////////////////////////
	// settings bank address map
	////////////////////////////////////////
	localparam logic [31:0] ADDR_MULTITAP  = 32'h0000_0000;
	localparam logic [31:0] ADDR_AR        = 32'h0000_0010;
	localparam logic [31:0] ADDR_COMPOSITE = 32'h0000_0020;
	localparam logic [31:0] ADDR_OBJ_LIMIT = 32'h0000_0030;
	localparam logic [31:0] ADDR_FM        = 32'h0000_0040;
	localparam logic [31:0] ADDR_PSG       = 32'h0000_0050;
	localparam logic [31:0] ADDR_HIFI      = 32'h0000_0060;
	localparam logic [31:0] ADDR_LADDER    = 32'h0000_0070;
	localparam logic [31:0] ADDR_FM_CHIP   = 32'h00A0_0000;
	localparam logic [31:0] ADDR_TURBO     = 32'h00C0_0000;
	localparam logic [31:0] ADDR_REGION    = 32'h00E0_0000; // read only
	localparam logic [31:0] ADDR_FILTER    = 32'h00F0_0000;

	// video and audio on, everything else off
	localparam core_settings_t SETTINGS_RESET = '{
		cpu_turbo: 2'd0, multitap: 1'b0, ar_correction: 1'b0, composite: 1'b0,
		obj_limit_high: 1'b1, fm_enable: 1'b1, psg_enable: 1'b1, hifi_pcm: 1'b1,
		ladder: 1'b1, audio_filter: 2'd0, fm_chip: 1'b0
	};

endpackage

`default_nettype wire

// ==== design/cart_info_pkg.sv ====
////////////////////////////////////////
// rom write word, header offsets, region codes
// quirk and light gun types, cartridge id table
// console pad layout
////////////////////////////////////////

`default_nettype none

package cart_info_pkg;

	typedef struct packed {
		logic        wr;
		logic [24:0] addr; // byte address
		logic [15:0] data;
	} rom_word_t;

	// header offsets
	localparam logic [24:0] HDR_ID0     = 25'h182;
	localparam logic [24:0] HDR_ID1     = 25'h184;
	localparam logic [24:0] HDR_ID2     = 25'h186;
	localparam logic [24:0] HDR_ID3     = 25'h188;
	localparam logic [24:0] HDR_ID4     = 25'h18A;
	localparam logic [24:0] HDR_ID5     = 25'h18C; // id complete here
	localparam logic [24:0] HDR_REGION0 = 25'h1F0;
	localparam logic [24:0] HDR_REGION2 = 25'h1F2;
	localparam logic [24:0] HDR_END     = 25'h200;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	typedef struct packed {
		logic sram;
		logic sram00;
		logic eeprom;
		logic fifo;
		logic noram;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} quirk_flags_t;

	typedef struct packed {
		logic       gun_type;
		logic [7:0] sensor_delay;
	} gun_cfg_t;

	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

	////////////////////////////////////////
	// cartridge ids, as read from the header
	////////////////////////////////////////
	localparam logic [63:0] ID_NFL_QBC      = "T-081276";
	localparam logic [63:0] ID_NBA_JAM_TE   = "T-81406 ";
	localparam logic [63:0] ID_HOLYFIELD    = "MK-1215 ";
	localparam logic [63:0] ID_WONDER_BOY   = "G-4060  ";
	localparam logic [63:0] ID_PUGGSY       = "T-113016";
	localparam logic [63:0] ID_CLUE         = "T-89016 ";
	localparam logic [63:0] ID_PIER_SOLAR   = "T-574023";
	localparam logic [63:0] ID_VIRTUA_RACE  = "MK-1229 ";
	localparam logic [63:0] ID_HELLFIRE     = "T-35036 ";
	localparam logic [63:0] ID_KANZUME      = "T-68???-";
	localparam logic [63:0] ID_SONIC_REMAST = " GM 0000";
	// light gun titles
	localparam logic [63:0] ID_BODY_COUNT   = "MK-1533 ";
	localparam logic [63:0] ID_LETHAL_ENF   = "T-95096-";
	localparam logic [63:0] ID_LETHAL_ENF2  = "T-95136-";
	localparam logic [63:0] ID_MENACER      = "MK-1658 ";
	localparam logic [63:0] ID_T2_ARCADE    = "T-081156";

	localparam logic [7:0] GUN_DELAY_BODY_COUNT = 8'd100;
	localparam logic [7:0] GUN_DELAY_LETHAL_ENF = 8'd52;
	localparam logic [7:0] GUN_DELAY_LETHAL_ENF2 = 8'd30;
	localparam logic [7:0] GUN_DELAY_MENACER    = 8'd120;
	localparam logic [7:0] GUN_DELAY_T2_ARCADE  = 8'd126;

	typedef struct packed {
		logic z, y, x, mode, start, b, c, a;
		logic up, down, left, right;
	} pad_t;

endpackage

`default_nettype wire

// ==== design/bridge_settings_regs.sv ====
////////////////////////////////////////
// settings register bank on the bridge bus
// registered bridge read port
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bridge_settings_regs (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire cart_bus_pkg::bridge_bus_t bridge,
	input  wire cart_info_pkg::region_t  region_req,
	output cart_bus_pkg::core_settings_t settings,
	output logic [31:0]                  bridge_rd_data
);

	////////////////////////////////////////
	// write decode
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			settings <= cart_bus_pkg::SETTINGS_RESET;
		end else if (bridge.wr) begin
			case (bridge.addr)
				cart_bus_pkg::ADDR_MULTITAP:  settings.multitap       <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_AR:        settings.ar_correction  <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_COMPOSITE: settings.composite      <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_OBJ_LIMIT: settings.obj_limit_high <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_FM:        settings.fm_enable      <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_PSG:       settings.psg_enable     <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_HIFI:      settings.hifi_pcm       <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_LADDER:    settings.ladder         <= bridge.wr_data[0];
				cart_bus_pkg::ADDR_FM_CHIP:   settings.fm_chip        <= bridge.wr_data[0];
				// two bit fields
				cart_bus_pkg::ADDR_TURBO:     settings.cpu_turbo      <= bridge.wr_data[1:0];
				cart_bus_pkg::ADDR_FILTER:    settings.audio_filter   <= bridge.wr_data[1:0];
				default: ;
			endcase
		end
	end

	// only the region is readable, the rest of the map reads as zero
	always_ff @(posedge clk_sys) begin
		if (bridge.rd) begin
			if (bridge.addr == cart_bus_pkg::ADDR_REGION)
				bridge_rd_data <= {30'd0, region_req};
			else
				bridge_rd_data <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== design/cart_download_ctrl.sv ====
////////////////////////////////////////
// download level with start and end pulses
// rom size capture
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cart_download_ctrl (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          request_write,
	input  wire                          all_complete,
	input  wire cart_info_pkg::rom_word_t rom_wr,
	output logic                         download,
	output logic                         dl_start,
	output logic                         dl_end,
	output logic [24:0]                  rom_size
);

	logic        download_q;
	logic [24:0] last_addr;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download   <= 1'b0;
			download_q <= 1'b0;
		end else begin
			if (request_write)
				download <= 1'b1;
			else if (all_complete)
				download <= 1'b0;
			download_q <= download;
		end
	end

	assign dl_start = download & ~download_q;
	assign dl_end   = ~download & download_q;

	always_ff @(posedge clk_sys) begin
		if (rom_wr.wr && download)
			last_addr <= rom_wr.addr;
		if (dl_end)
			rom_size <= last_addr + 25'd2; // last word plus one more word
	end

endmodule

`default_nettype wire

// ==== design/rom_header_region.sv ====
////////////////////////////////////////
// region flags from the rom header
// region request and core reset hold
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rom_header_region (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          reset_n_host,
	input  wire cart_info_pkg::rom_word_t rom_wr,
	input  wire                          download,
	input  wire                          dl_start,
	input  wire                          dl_end,
	output cart_info_pkg::region_t       region_req,
	output logic                         region_set,
	output logic                         core_reset_n
);

	logic       hdr_j, hdr_u, hdr_e;
	logic       hdr_ready, hdr_ready_q;
	logic       hdr_wr;
	logic [7:0] lo, hi;
	logic [3:0] hrgn;

	assign hdr_wr = rom_wr.wr & download;
	assign lo     = rom_wr.data[7:0];
	assign hi     = rom_wr.data[15:8];
	assign hrgn   = rom_wr.data[3:0] - 4'd7; // hex letter to value

	////////////////////////////////////////
	// header scan
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready             <= 1'b0;
		end else begin
			if (dl_start) {hdr_j, hdr_u, hdr_e} <= 3'b000;
			if (dl_end) hdr_ready <= 1'b0;
			if (hdr_wr && rom_wr.addr == cart_info_pkg::HDR_REGION0) begin
				if (lo == "J") hdr_j <= 1'b1;
				else if (lo == "U") hdr_u <= 1'b1;
				else if (lo == "E") hdr_e <= 1'b1;
				else if (lo >= "0" && lo <= "9")
					{hdr_e, hdr_u, hdr_j} <= {lo[3], lo[2], lo[0]};
				else if (lo >= "A" && lo <= "F")
					{hdr_e, hdr_u, hdr_j} <= {hrgn[3], hrgn[2], hrgn[0]};
				// high byte last, so a letter there wins
				if (hi == "J") hdr_j <= 1'b1;
				else if (hi == "U") hdr_u <= 1'b1;
				else if (hi == "E") hdr_e <= 1'b1;
			end
			if (hdr_wr && rom_wr.addr == cart_info_pkg::HDR_REGION2) begin
				if (lo == "J") hdr_j <= 1'b1;
				else if (lo == "U") hdr_u <= 1'b1;
				else if (lo == "E") hdr_e <= 1'b1;
			end
			if (hdr_wr && rom_wr.addr == cart_info_pkg::HDR_END) hdr_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hdr_ready_q <= 1'b0;
			region_set  <= 1'b0;
			region_req  <= cart_info_pkg::REGION_US;
		end else begin
			hdr_ready_q <= hdr_ready;
			if (hdr_ready && !hdr_ready_q) begin
				region_set <= 1'b1;
				if (hdr_u)      region_req <= cart_info_pkg::REGION_US;
				else if (hdr_e) region_req <= cart_info_pkg::REGION_EU;
				else if (hdr_j) region_req <= cart_info_pkg::REGION_JP;
				else            region_req <= cart_info_pkg::REGION_US;
			end
			if (!hdr_ready && hdr_ready_q) region_set <= 1'b0;
		end
	end

	assign core_reset_n = reset_n_host & ~region_set; // console held while region applies

endmodule

`default_nettype wire

// ==== design/cart_id_quirks.sv ====
////////////////////////////////////////
// cartridge id from the header
// quirk flags and light gun lookup
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cart_id_quirks (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire cart_info_pkg::rom_word_t rom_wr,
	input  wire                          download,
	input  wire                          dl_start,
	output cart_info_pkg::quirk_flags_t  quirks,
	output cart_info_pkg::gun_cfg_t      gun_cfg
);

	logic                        id_wr;
	logic [63:0]                 cart_id;
	cart_info_pkg::quirk_flags_t quirk_hit;
	cart_info_pkg::gun_cfg_t     gun_hit;

	assign id_wr = rom_wr.wr & download;

	// header words are big endian, so swap bytes
	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			case (rom_wr.addr)
				cart_info_pkg::HDR_ID0: cart_id[63:56] <= rom_wr.data[15:8];
				cart_info_pkg::HDR_ID1: cart_id[55:40] <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				cart_info_pkg::HDR_ID2: cart_id[39:24] <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				cart_info_pkg::HDR_ID3: cart_id[23:8]  <= {rom_wr.data[7:0], rom_wr.data[15:8]};
				cart_info_pkg::HDR_ID4: cart_id[7:0]   <= rom_wr.data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// id table
	////////////////////////////////////////
	always_comb begin
		quirk_hit = '0;
		case (cart_id)
			cart_info_pkg::ID_NFL_QBC,
			cart_info_pkg::ID_NBA_JAM_TE:   quirk_hit.sram   = 1'b1;
			cart_info_pkg::ID_HOLYFIELD,
			cart_info_pkg::ID_WONDER_BOY:   quirk_hit.eeprom = 1'b1;
			cart_info_pkg::ID_PUGGSY:       quirk_hit.noram  = 1'b1; // fake ram check
			cart_info_pkg::ID_CLUE:         quirk_hit.fifo   = 1'b1;
			cart_info_pkg::ID_PIER_SOLAR:   quirk_hit.pier   = 1'b1;
			cart_info_pkg::ID_VIRTUA_RACE:  quirk_hit.svp    = 1'b1;
			cart_info_pkg::ID_HELLFIRE:     quirk_hit.fmbusy = 1'b1;
			cart_info_pkg::ID_KANZUME:      quirk_hit.schan  = 1'b1;
			cart_info_pkg::ID_SONIC_REMAST: quirk_hit.sram00 = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		gun_hit = '{gun_type: 1'b0, sensor_delay: cart_info_pkg::GUN_DELAY_DEFAULT};
		case (cart_id)
			cart_info_pkg::ID_BODY_COUNT:
				gun_hit.sensor_delay = cart_info_pkg::GUN_DELAY_BODY_COUNT;
			cart_info_pkg::ID_LETHAL_ENF:
				gun_hit = '{gun_type: 1'b1, sensor_delay: cart_info_pkg::GUN_DELAY_LETHAL_ENF};
			cart_info_pkg::ID_LETHAL_ENF2:
				gun_hit = '{gun_type: 1'b1, sensor_delay: cart_info_pkg::GUN_DELAY_LETHAL_ENF2};
			cart_info_pkg::ID_MENACER:
				gun_hit.sensor_delay = cart_info_pkg::GUN_DELAY_MENACER;
			cart_info_pkg::ID_T2_ARCADE:
				gun_hit.sensor_delay = cart_info_pkg::GUN_DELAY_T2_ARCADE;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			quirks  <= '0;
			gun_cfg <= '{gun_type: 1'b0, sensor_delay: cart_info_pkg::GUN_DELAY_DEFAULT};
		end else begin
			if (dl_start) quirks <= '0;
			if (id_wr && rom_wr.addr == cart_info_pkg::HDR_ID5) begin
				quirks  <= quirks | quirk_hit;
				gun_cfg <= gun_hit;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/pad_remap.sv ====
////////////////////////////////////////
// controller and menu flag synchronizers
// key bitmap to console pad remap
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pad_remap (
	input  wire               clk_sys,
	input  wire               rst_n,
	input  wire [3:0][15:0]   cont_keys,
	input  wire               osnotify_inmenu,
	output cart_info_pkg::pad_t [3:0] pads,
	output logic              pause
);

	logic [3:0][15:0] key_s1, key_s2, key_s3;
	logic [2:0]       menu_sync;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			key_s1    <= '0;
			key_s2    <= '0;
			key_s3    <= '0;
			menu_sync <= '0;
		end else begin
			key_s1    <= cont_keys;
			key_s2    <= key_s1;
			key_s3    <= key_s2;
			menu_sync <= {menu_sync[1:0], osnotify_inmenu};
		end
	end

	assign pause = menu_sync[2];

	// Z Y X mode start B C A, then the dpad
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			pads[i] = {key_s3[i][9], key_s3[i][6], key_s3[i][8], key_s3[i][14],
				key_s3[i][15], key_s3[i][4], key_s3[i][5], key_s3[i][7],
				key_s3[i][0], key_s3[i][1], key_s3[i][2], key_s3[i][3]};
		end
	end

endmodule

`default_nettype wire

// ==== design/cart_frontend_top.sv ====
////////////////////////////////////////
// cartridge and host front end top level
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cart_frontend_top (
	input  wire                                clk_sys,
	input  wire                                rst_n,
	input  wire cart_bus_pkg::bridge_bus_t     bridge,
	output wire [31:0]                         bridge_rd_data,
	input  wire cart_info_pkg::rom_word_t      rom_wr,
	input  wire                                reset_n_host,
	input  wire                                request_write,
	input  wire                                all_complete,
	input  wire                                osnotify_inmenu,
	input  wire [3:0][15:0]                    cont_keys,
	output wire cart_bus_pkg::core_settings_t  settings,
	output wire cart_info_pkg::quirk_flags_t   quirks,
	output wire cart_info_pkg::gun_cfg_t       gun_cfg,
	output wire [24:0]                         rom_size,
	output wire                                core_reset_n,
	output wire cart_info_pkg::pad_t [3:0]     pads,
	output wire                                pause
);

	wire                         download;
	wire                         dl_start;
	wire                         dl_end;
	wire                         region_set;
	wire cart_info_pkg::region_t region_req;

	bridge_settings_regs i_bridge_settings_regs (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.bridge         (bridge),
		.region_req     (region_req),
		.settings       (settings),
		.bridge_rd_data (bridge_rd_data)
	);

	cart_download_ctrl i_cart_download_ctrl (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.request_write (request_write),
		.all_complete  (all_complete),
		.rom_wr        (rom_wr),
		.download      (download),
		.dl_start      (dl_start),
		.dl_end        (dl_end),
		.rom_size      (rom_size)
	);

	rom_header_region i_rom_header_region (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.reset_n_host (reset_n_host),
		.rom_wr       (rom_wr),
		.download     (download),
		.dl_start     (dl_start),
		.dl_end       (dl_end),
		.region_req   (region_req),
		.region_set   (region_set),
		.core_reset_n (core_reset_n)
	);

	cart_id_quirks i_cart_id_quirks (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rom_wr   (rom_wr),
		.download (download),
		.dl_start (dl_start),
		.quirks   (quirks),
		.gun_cfg  (gun_cfg)
	);

	pad_remap i_pad_remap (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.cont_keys       (cont_keys),
		.osnotify_inmenu (osnotify_inmenu),
		.pads            (pads),
		.pause           (pause)
	);

endmodule

`default_nettype wire

// ==== verif/cart_frontend_assertions.sv ====
////////////////////////////////////////
// concurrent checks on the front end top level
// download pulses, core reset hold, bridge read data
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cart_frontend_assertions (
	input wire                            clk_sys,
	input wire                            rst_n,
	input wire cart_bus_pkg::bridge_bus_t bridge,
	input wire [31:0]                     bridge_rd_data,
	input wire                            dl_start,
	input wire                            dl_end,
	input wire                            region_set,
	input wire                            core_reset_n
);

	// download edges are single cycle events
	a_dl_start_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_start |=> !dl_start)
		else $error("dl_start held for more than one cycle");

	a_dl_end_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_end |=> !dl_end)
		else $error("dl_end held for more than one cycle");

	a_reset_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		region_set |-> !core_reset_n)
		else $error("console left running while region is applied");

	a_unmapped_read: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(bridge.rd && bridge.addr != cart_bus_pkg::ADDR_REGION) |=> (bridge_rd_data == '0))
		else $error("unmapped bridge read returned nonzero data");

endmodule

`default_nettype wire

// ==== verif/cart_frontend_tb.sv ====
////////////////////////////////////////
// testbench for the cartridge front end
// settings bank, download and header scan
// quirk lookup, pad remap, reference models
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cart_frontend_tb;

	localparam int WAIT_LIMIT = 16;

	// writable settings, then the read only region and a hole in the map
	localparam logic [31:0] SETTING_ADDRS [13] = '{
		cart_bus_pkg::ADDR_MULTITAP, cart_bus_pkg::ADDR_AR, cart_bus_pkg::ADDR_COMPOSITE,
		cart_bus_pkg::ADDR_OBJ_LIMIT, cart_bus_pkg::ADDR_FM, cart_bus_pkg::ADDR_PSG,
		cart_bus_pkg::ADDR_HIFI, cart_bus_pkg::ADDR_LADDER, cart_bus_pkg::ADDR_FM_CHIP,
		cart_bus_pkg::ADDR_TURBO, cart_bus_pkg::ADDR_FILTER, cart_bus_pkg::ADDR_REGION,
		32'h0000_0080
	};

	logic                          clk_sys = 1'b0;
	logic                          rst_n;
	cart_bus_pkg::bridge_bus_t     bridge;
	wire [31:0]                    bridge_rd_data;
	cart_info_pkg::rom_word_t      rom_wr;
	logic                          reset_n_host;
	logic                          request_write;
	logic                          all_complete;
	logic                          osnotify_inmenu;
	logic [3:0][15:0]              cont_keys;
	cart_bus_pkg::core_settings_t  settings;
	cart_info_pkg::quirk_flags_t   quirks;
	cart_info_pkg::gun_cfg_t       gun_cfg;
	wire [24:0]                    rom_size;
	wire                           core_reset_n;
	cart_info_pkg::pad_t [3:0]     pads;
	wire                           pause;
	logic [31:0]                   lfsr_state = 32'hf2c0;

	always #4 clk_sys = ~clk_sys; // 8 ns period

	cart_frontend_top i_cart_frontend_top (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.bridge          (bridge),
		.bridge_rd_data  (bridge_rd_data),
		.rom_wr          (rom_wr),
		.reset_n_host    (reset_n_host),
		.request_write   (request_write),
		.all_complete    (all_complete),
		.osnotify_inmenu (osnotify_inmenu),
		.cont_keys       (cont_keys),
		.settings        (settings),
		.quirks          (quirks),
		.gun_cfg         (gun_cfg),
		.rom_size        (rom_size),
		.core_reset_n    (core_reset_n),
		.pads            (pads),
		.pause           (pause)
	);

	bind cart_frontend_top cart_frontend_assertions i_cart_frontend_assertions (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.bridge         (bridge),
		.bridge_rd_data (bridge_rd_data),
		.dl_start       (dl_start),
		.dl_end         (dl_end),
		.region_set     (region_set),
		.core_reset_n   (core_reset_n)
	);

	////////////////////////////////////////
	// random source
	////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int b = 0; b < count; b++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return value;
	endfunction

	////////////////////////////////////////
	// reference models
	////////////////////////////////////////
	function automatic cart_bus_pkg::core_settings_t apply_setting(
		input cart_bus_pkg::core_settings_t s, input logic [31:0] addr,
		input logic [31:0] data);
		cart_bus_pkg::core_settings_t n;
		n = s;
		if (addr == cart_bus_pkg::ADDR_MULTITAP) n.multitap = data[0];
		if (addr == cart_bus_pkg::ADDR_AR) n.ar_correction = data[0];
		if (addr == cart_bus_pkg::ADDR_COMPOSITE) n.composite = data[0];
		if (addr == cart_bus_pkg::ADDR_OBJ_LIMIT) n.obj_limit_high = data[0];
		if (addr == cart_bus_pkg::ADDR_FM) n.fm_enable = data[0];
		if (addr == cart_bus_pkg::ADDR_PSG) n.psg_enable = data[0];
		if (addr == cart_bus_pkg::ADDR_HIFI) n.hifi_pcm = data[0];
		if (addr == cart_bus_pkg::ADDR_LADDER) n.ladder = data[0];
		if (addr == cart_bus_pkg::ADDR_FM_CHIP) n.fm_chip = data[0];
		if (addr == cart_bus_pkg::ADDR_TURBO) n.cpu_turbo = data[1:0];
		if (addr == cart_bus_pkg::ADDR_FILTER) n.audio_filter = data[1:0];
		return n;
	endfunction

	// region chars at header bytes 0x1F0, 0x1F1 and 0x1F2
	function automatic cart_info_pkg::region_t expected_region(
		input logic [7:0] r0, input logic [7:0] r1, input logic [7:0] r2);
		logic       j, u, e;
		logic [7:0] v;
		{j, u, e} = 3'b000;
		v = r0 - 8'd7;
		if (r0 == "J" || r0 == "U" || r0 == "E") begin
			// letters handled below with the other bytes
		end else if (r0 >= "0" && r0 <= "9") begin
			{e, u, j} = {r0[3], r0[2], r0[0]};
		end else if (r0 >= "A" && r0 <= "F") begin
			{e, u, j} = {v[3], v[2], v[0]};
		end
		j = j | (r0 == "J") | (r1 == "J") | (r2 == "J");
		u = u | (r0 == "U") | (r1 == "U") | (r2 == "U");
		e = e | (r0 == "E") | (r1 == "E") | (r2 == "E");
		if (u) return cart_info_pkg::REGION_US;
		if (e) return cart_info_pkg::REGION_EU;
		if (j) return cart_info_pkg::REGION_JP;
		return cart_info_pkg::REGION_US;
	endfunction

	function automatic cart_info_pkg::quirk_flags_t expected_quirks(input logic [63:0] id);
		cart_info_pkg::quirk_flags_t q;
		q = '0;
		q.sram   = (id == cart_info_pkg::ID_NFL_QBC) || (id == cart_info_pkg::ID_NBA_JAM_TE);
		q.eeprom = (id == cart_info_pkg::ID_HOLYFIELD) || (id == cart_info_pkg::ID_WONDER_BOY);
		q.noram  = (id == cart_info_pkg::ID_PUGGSY);
		q.fifo   = (id == cart_info_pkg::ID_CLUE);
		q.pier   = (id == cart_info_pkg::ID_PIER_SOLAR);
		q.svp    = (id == cart_info_pkg::ID_VIRTUA_RACE);
		q.fmbusy = (id == cart_info_pkg::ID_HELLFIRE);
		q.schan  = (id == cart_info_pkg::ID_KANZUME);
		q.sram00 = (id == cart_info_pkg::ID_SONIC_REMAST);
		return q;
	endfunction

	function automatic cart_info_pkg::gun_cfg_t expected_gun(input logic [63:0] id);
		cart_info_pkg::gun_cfg_t g;
		g.gun_type     = 1'b0;
		g.sensor_delay = cart_info_pkg::GUN_DELAY_DEFAULT;
		if (id == cart_info_pkg::ID_BODY_COUNT) g.sensor_delay = 8'd100;
		if (id == cart_info_pkg::ID_MENACER) g.sensor_delay = 8'd120;
		if (id == cart_info_pkg::ID_T2_ARCADE) g.sensor_delay = 8'd126;
		if (id == cart_info_pkg::ID_LETHAL_ENF) g = '{gun_type: 1'b1, sensor_delay: 8'd52};
		if (id == cart_info_pkg::ID_LETHAL_ENF2) g = '{gun_type: 1'b1, sensor_delay: 8'd30};
		return g;
	endfunction

	function automatic cart_info_pkg::pad_t expected_pad(input logic [15:0] k);
		cart_info_pkg::pad_t p;
		p.z     = k[9];
		p.y     = k[6];
		p.x     = k[8];
		p.mode  = k[14];
		p.start = k[15];
		p.b     = k[4];
		p.c     = k[5];
		p.a     = k[7];
		p.up    = k[0];
		p.down  = k[1];
		p.left  = k[2];
		p.right = k[3];
		return p;
	endfunction

	// bytes from 0 up to and including the last word
	function automatic logic [24:0] expected_rom_size(input int extra_words);
		return cart_info_pkg::HDR_END + 25'(2 * extra_words) + 25'd2;
	endfunction

	////////////////////////////////////////
	// checks and bus tasks
	////////////////////////////////////////
	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_value(input string test_name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", test_name, expected, actual);
			stop_on_failure("output differs from the reference model");
		end
	endtask

	task automatic wait_core_reset(input logic level, input string test_name);
		int cycles;
		cycles = 0;
		while (core_reset_n !== level) begin
			if (cycles == WAIT_LIMIT) begin
				$display("core_reset_n never reached %0b in %s", level, test_name);
				stop_on_failure("timed out waiting for the core reset");
			end
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
		bridge.addr    = addr;
		bridge.wr_data = data;
		bridge.wr      = 1'b1;
		@(negedge clk_sys);
		bridge.wr = 1'b0;
	endtask

	task automatic bridge_read(input logic [31:0] addr);
		bridge.addr = addr;
		bridge.rd   = 1'b1;
		@(negedge clk_sys);
		bridge.rd = 1'b0;
	endtask

	task automatic rom_write(input logic [24:0] addr, input logic [15:0] data);
		rom_wr.addr = addr;
		rom_wr.data = data;
		rom_wr.wr   = 1'b1;
		@(negedge clk_sys);
		rom_wr.wr = 1'b0;
	endtask

	////////////////////////////////////////
	// test sequences
	////////////////////////////////////////
	task automatic settings_test();
		cart_bus_pkg::core_settings_t exp;
		logic [31:0] data;
		exp = cart_bus_pkg::SETTINGS_RESET;
		check_value("settings reset", 64'(exp), 64'(settings));
		for (int round = 0; round < 2; round++) begin
			for (int i = 0; i < 13; i++) begin
				data = rand_bits(32);
				bridge_write(SETTING_ADDRS[i], data);
				exp = apply_setting(exp, SETTING_ADDRS[i], data);
				check_value("settings write", 64'(exp), 64'(settings));
			end
		end
		bridge_read(32'h0000_0080);
		check_value("unmapped read", 64'd0, 64'(bridge_rd_data));
	endtask

	// stream words are little endian with the low byte at the even address
	task automatic run_download(input string test_name, input logic [63:0] id,
		input logic [7:0] r0, input logic [7:0] r1, input logic [7:0] r2);
		logic [31:0] rnd;
		int          extra;
		rnd   = rand_bits(3);
		extra = int'(rnd) + 1;
		request_write = 1'b1;
		@(negedge clk_sys);
		request_write = 1'b0;
		@(negedge clk_sys);
		check_value({test_name, " quirks clear"}, 64'd0, 64'(quirks));
		rom_write(cart_info_pkg::HDR_ID0, {id[63:56], " "});
		rom_write(cart_info_pkg::HDR_ID1, {id[47:40], id[55:48]});
		rom_write(cart_info_pkg::HDR_ID2, {id[31:24], id[39:32]});
		rom_write(cart_info_pkg::HDR_ID3, {id[15:8], id[23:16]});
		rom_write(cart_info_pkg::HDR_ID4, {"-", id[7:0]});
		rom_write(cart_info_pkg::HDR_ID5, "00");
		check_value({test_name, " quirks"}, 64'(expected_quirks(id)), 64'(quirks));
		check_value({test_name, " gun"}, 64'(expected_gun(id)), 64'(gun_cfg));
		rom_write(cart_info_pkg::HDR_REGION0, {r1, r0});
		rom_write(cart_info_pkg::HDR_REGION2, {" ", r2});
		rom_write(cart_info_pkg::HDR_END, 16'h0000);
		wait_core_reset(1'b0, test_name);
		bridge_read(cart_bus_pkg::ADDR_REGION);
		check_value({test_name, " region"}, 64'(expected_region(r0, r1, r2)),
			64'(bridge_rd_data));
		for (int w = 1; w <= extra; w++) begin
			rnd = rand_bits(16);
			rom_write(cart_info_pkg::HDR_END + 25'(2 * w), rnd[15:0]);
			check_value({test_name, " reset held"}, 64'd0, 64'(core_reset_n));
		end
		all_complete = 1'b1;
		@(negedge clk_sys);
		all_complete = 1'b0;
		@(negedge clk_sys);
		check_value({test_name, " rom size"}, 64'(expected_rom_size(extra)), 64'(rom_size));
		wait_core_reset(1'b1, test_name);
	endtask

	task automatic pad_test(input int rounds);
		cart_info_pkg::pad_t [3:0] exp_old, exp_new;
		logic [3:0][15:0]          keys;
		logic                      menu, menu_old;
		logic [31:0]               rnd;
		exp_old  = '0;
		menu_old = 1'b0;
		for (int r = 0; r < rounds; r++) begin
			for (int i = 0; i < 4; i++) begin
				rnd     = rand_bits(16);
				keys[i] = rnd[15:0];
				exp_new[i] = expected_pad(keys[i]);
			end
			rnd  = rand_bits(1);
			menu = rnd[0];
			cont_keys       = keys;
			osnotify_inmenu = menu;
			repeat (2) @(negedge clk_sys);
			check_value("pads before sync", 64'(exp_old), 64'(pads));
			check_value("pause before sync", 64'(menu_old), 64'(pause));
			@(negedge clk_sys);
			check_value("pads after sync", 64'(exp_new), 64'(pads));
			check_value("pause after sync", 64'(menu), 64'(pause));
			exp_old  = exp_new;
			menu_old = menu;
		end
	endtask

	initial begin
		rst_n           = 1'b0;
		bridge          = '0;
		rom_wr          = '0;
		reset_n_host    = 1'b1;
		request_write   = 1'b0;
		all_complete    = 1'b0;
		osnotify_inmenu = 1'b0;
		cont_keys       = '0;
		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;

		check_value("reset quirks", 64'd0, 64'(quirks));
		check_value("reset gun", 64'({1'b0, cart_info_pkg::GUN_DELAY_DEFAULT}), 64'(gun_cfg));
		check_value("reset core run", 64'd1, 64'(core_reset_n));
		bridge_read(cart_bus_pkg::ADDR_REGION);
		check_value("reset region", 64'(cart_info_pkg::REGION_US), 64'(bridge_rd_data));
		settings_test();

		reset_n_host = 1'b0;
		@(negedge clk_sys);
		check_value("host reset", 64'd0, 64'(core_reset_n));
		reset_n_host = 1'b1;
		@(negedge clk_sys);
		check_value("host release", 64'd1, 64'(core_reset_n));

		run_download("jp letter", cart_info_pkg::ID_NFL_QBC, "J", " ", " ");
		run_download("us letter", cart_info_pkg::ID_HOLYFIELD, "U", " ", " ");
		run_download("eu letter", cart_info_pkg::ID_PUGGSY, "E", " ", " ");
		run_download("digit jp", cart_info_pkg::ID_BODY_COUNT, "1", " ", " ");
		run_download("digit eu", cart_info_pkg::ID_LETHAL_ENF, "8", " ", " ");
		run_download("hex eu", cart_info_pkg::ID_CLUE, "A", " ", " ");
		run_download("hex us", cart_info_pkg::ID_HELLFIRE, "D", " ", " ");
		run_download("high byte", cart_info_pkg::ID_SONIC_REMAST, "J", "E", " ");
		run_download("no region", cart_info_pkg::ID_KANZUME, " ", " ", " ");
		run_download("third byte", cart_info_pkg::ID_MENACER, " ", " ", "J");
		run_download("unknown id", "T-000000", "4", " ", " ");

		pad_test(12);

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
design/cart_bus_pkg.sv
design/cart_info_pkg.sv
design/bridge_settings_regs.sv
design/cart_download_ctrl.sv
design/rom_header_region.sv
design/cart_id_quirks.sv
design/pad_remap.sv
design/cart_frontend_top.sv
verif/cart_frontend_assertions.sv
verif/cart_frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the front end testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cart_frontend_tb -f sources.f > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/Vcart_frontend_tb > sim.log 2>&1
sim_status=$?

if grep -q "Testbench failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status, see sim.log"
	exit 1
fi
echo "simulation finished without failures"
exit 0
